// File: cjtag_pkg.sv
// IEEE 1149.7 OScan1 protocol constants
// Escape windows, online activation code and packet bit order
package cjtag_pkg;

    // ==============================
    // Online activation code
    // ==============================
    // Sent LSB first after a selection escape
    localparam logic [3:0] OAC_CODE = 4'b1011;
    localparam int         OAC_BITS = 4;

    // ==============================
    // Escape classification
    // ==============================
    // Counts are TMSC toggles seen during one TCKC high phase
    localparam logic [4:0] ESC_DESELECT_MIN = 5'd4;
    localparam logic [4:0] ESC_SELECT_MIN   = 5'd6;
    localparam logic [4:0] ESC_SELECT_MAX   = 5'd7;
    // Anything at or above this returns the bridge offline
    localparam logic [4:0] ESC_RESET_MIN    = 5'd8;

    // ==============================
    // OScan1 packet bit positions
    // ==============================
    localparam logic [1:0] PKT_NTDI = 2'd0;
    localparam logic [1:0] PKT_TMS  = 2'd1;
    // Third bit, driven back by the target
    localparam logic [1:0] PKT_TDO  = 2'd2;

endpackage

// File: bridge_pkg.sv
// Bridge implementation types and widths
// Counter sizes, synchroniser depth, pin indices and FSM encoding
package bridge_pkg;

    // ==============================
    // Widths and depths
    // ==============================
    // Toggle counter saturates at 31
    localparam int TOGGLE_W    = 5;
    // Flops in front of the edge detector
    localparam int SYNC_STAGES = 2;

    // ==============================
    // Sampled pins
    // ==============================
    localparam int NUM_PINS = 2;
    // Indices into the sampler arrays of the top level
    localparam int PIN_TCKC = 0;
    localparam int PIN_TMSC = 1;

    // ==============================
    // Controller state
    // ==============================
    typedef enum logic [1:0] {
        ST_OFFLINE    = 2'b00,
        ST_ONLINE_ACT = 2'b01,
        ST_OSCAN1     = 2'b10
    } bridge_state_t;

    // Bit position inside the three-bit OScan1 packet
    typedef logic [1:0] pkt_pos_t;

endpackage

// File: pin_sampler.sv
// Pin sampler for one cJTAG pin
// Synchronises the asynchronous pin and flags rising, falling and any edge
`timescale 1ns/1ps

module pin_sampler (
    input  logic clk_i,
    input  logic ntrst_i,
    input  logic pin_i,
    output logic level_o,
    output logic rise_o,
    output logic fall_o,
    output logic toggle_o
);
    import bridge_pkg::*;

    logic [SYNC_STAGES-1:0] sync_q;
    logic                   prev_q;
    logic                   level;

    // ==============================
    // Synchroniser
    // ==============================
    // First stage samples an asynchronous pin and may go metastable,
    // the later stages give it a full cycle to settle
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], pin_i};
        end
    end

    assign level   = sync_q[SYNC_STAGES-1];
    assign level_o = level;

    // ==============================
    // Edge pulses
    // ==============================
    // Compare settled level against last cycle, register one-clock pulses
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            prev_q   <= 1'b0;
            rise_o   <= 1'b0;
            fall_o   <= 1'b0;
            toggle_o <= 1'b0;
        end else begin
            prev_q   <= level;
            rise_o   <= level & ~prev_q;
            fall_o   <= ~level & prev_q;
            toggle_o <= level ^ prev_q;
        end
    end

endmodule

// File: escape_detector.sv
// Escape detector
// Counts TMSC toggles during each TCKC high phase and classifies
// the count as deselection, selection or reset
`timescale 1ns/1ps

module escape_detector (
    input  logic clk_i,
    input  logic ntrst_i,
    input  logic tckc_rise_i,
    input  logic tckc_fall_i,
    input  logic tckc_level_i,
    input  logic tmsc_toggle_i,
    output logic esc_select_o,
    output logic esc_reset_o,
    output logic esc_deselect_o
);
    import cjtag_pkg::*;
    import bridge_pkg::*;

    logic [TOGGLE_W-1:0] toggle_cnt_q;
    logic                high_q;
    logic                count_en;

    // ==============================
    // Toggle counter
    // ==============================
    // Only count while a high phase is open and TCKC still reads high
    assign count_en = high_q & tckc_level_i & tmsc_toggle_i;

    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            toggle_cnt_q <= '0;
            high_q       <= 1'b0;
        end else begin
            if (tckc_rise_i) begin
                // New high phase starts from zero
                toggle_cnt_q <= '0;
                high_q       <= 1'b1;
            end else if (tckc_fall_i) begin
                // Count is kept so the fall cycle can classify it
                high_q <= 1'b0;
            end else if (count_en && (toggle_cnt_q != '1)) begin
                // Saturate instead of wrapping back into a valid window
                toggle_cnt_q <= toggle_cnt_q + 1'b1;
            end
        end
    end

    // ==============================
    // Classification
    // ==============================
    // Combinational, consumed in the cycle of the TCKC fall pulse
    assign esc_deselect_o = (toggle_cnt_q >= ESC_DESELECT_MIN) &&
                            (toggle_cnt_q <  ESC_SELECT_MIN);
    assign esc_select_o   = (toggle_cnt_q >= ESC_SELECT_MIN) &&
                            (toggle_cnt_q <= ESC_SELECT_MAX);
    // Reset window is open ended
    assign esc_reset_o    = (toggle_cnt_q >= ESC_RESET_MIN);

endmodule

// File: oscan1_controller.sv
// OScan1 controller
// Offline, activation and OScan1 FSM with online activation code check,
// packet bit position tracking and TMSC capture on TCKC falls
`timescale 1ns/1ps

module oscan1_controller (
    input  logic                      clk_i,
    input  logic                      ntrst_i,
    input  logic                      tckc_fall_i,
    input  logic                      tmsc_level_i,
    input  logic                      esc_select_i,
    input  logic                      esc_reset_i,
    output bridge_pkg::bridge_state_t state_o,
    output bridge_pkg::pkt_pos_t      pkt_pos_o,
    output logic                      tmsc_bit_o,
    output logic                      online_o,
    output logic                      nsp_o
);
    import cjtag_pkg::*;
    import bridge_pkg::*;

    bridge_state_t                  state_q;
    pkt_pos_t                       pkt_pos_q;
    logic [$clog2(OAC_BITS)-1:0]    oac_cnt_q;
    logic [OAC_BITS-2:0]            oac_shift_q;
    logic                           tmsc_bit_q;
    logic [OAC_BITS-1:0]            oac_word;
    logic                           oac_last;

    // ==============================
    // Activation code assembly
    // ==============================
    // Last bit comes straight from the pin, earlier bits from the shifter
    assign oac_word = {tmsc_level_i, oac_shift_q};
    assign oac_last = (oac_cnt_q == ($bits(oac_cnt_q))'(OAC_BITS - 1));

    // ==============================
    // State machine
    // ==============================
    // Everything moves on a TCKC fall, when the escape count is final
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            state_q   <= ST_OFFLINE;
            pkt_pos_q <= PKT_NTDI;
            oac_cnt_q <= '0;
        end else if (tckc_fall_i) begin
            if (esc_reset_i) begin
                // Reset escape overrides any state
                state_q   <= ST_OFFLINE;
                pkt_pos_q <= PKT_NTDI;
                oac_cnt_q <= '0;
            end else begin
                case (state_q)
                    ST_OFFLINE: begin
                        // Deselection and short escapes leave us here
                        if (esc_select_i) begin
                            state_q   <= ST_ONLINE_ACT;
                            oac_cnt_q <= '0;
                        end
                    end

                    ST_ONLINE_ACT: begin
                        if (oac_last) begin
                            oac_cnt_q <= '0;
                            pkt_pos_q <= PKT_NTDI;
                            // Wrong code drops back offline
                            state_q   <= (oac_word == OAC_CODE) ? ST_OSCAN1 : ST_OFFLINE;
                        end else begin
                            oac_cnt_q <= oac_cnt_q + 1'b1;
                        end
                    end

                    ST_OSCAN1: begin
                        // nTDI, TMS, TDO then wrap
                        case (pkt_pos_q)
                            PKT_NTDI: pkt_pos_q <= PKT_TMS;
                            PKT_TMS:  pkt_pos_q <= PKT_TDO;
                            default:  pkt_pos_q <= PKT_NTDI;
                        endcase
                    end

                    default: begin
                        state_q   <= ST_OFFLINE;
                        pkt_pos_q <= PKT_NTDI;
                    end
                endcase
            end
        end
    end

    // ==============================
    // Captured data
    // ==============================
    // Bit just sampled and the activation code shifter, LSB first
    always_ff @(posedge clk_i) begin
        if (tckc_fall_i) begin
            tmsc_bit_q <= tmsc_level_i;
            if (state_q == ST_ONLINE_ACT) begin
                oac_shift_q <= {tmsc_level_i, oac_shift_q[OAC_BITS-2:1]};
            end
        end
    end

    assign state_o    = state_q;
    assign pkt_pos_o  = pkt_pos_q;
    assign tmsc_bit_o = tmsc_bit_q;

    // Status pins
    assign online_o = (state_q == ST_OSCAN1);
    assign nsp_o    = (state_q != ST_OSCAN1);

endmodule

// File: tap_driver.sv
// TAP driver
// Registers TCK, TMS, TDI and the TMSC output enable from the OScan1
// packet, and returns TDO on TMSC during the third packet bit
`timescale 1ns/1ps

module tap_driver (
    input  logic                      clk_i,
    input  logic                      ntrst_i,
    input  logic                      tckc_rise_i,
    input  logic                      tckc_fall_i,
    input  bridge_pkg::bridge_state_t state_i,
    input  bridge_pkg::pkt_pos_t      pkt_pos_i,
    input  logic                      tmsc_bit_i,
    input  logic                      tdo_i,
    output logic                      tck_o,
    output logic                      tms_o,
    output logic                      tdi_o,
    output logic                      tmsc_o,
    output logic                      tmsc_oen_o
);
    import cjtag_pkg::*;
    import bridge_pkg::*;

    logic in_oscan1;
    logic tdo_slot;

    assign in_oscan1 = (state_i == ST_OSCAN1);
    assign tdo_slot  = in_oscan1 && (pkt_pos_i == PKT_TDO);

    // ==============================
    // JTAG side registers
    // ==============================
    // oen is active low, 1 means TMSC is an input
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            tck_o      <= 1'b0;
            tms_o      <= 1'b1;
            tdi_o      <= 1'b0;
            tmsc_oen_o <= 1'b1;
        end else if (!in_oscan1) begin
            // Idle TAP while offline or activating
            tck_o      <= 1'b0;
            tms_o      <= 1'b1;
            tdi_o      <= 1'b0;
            tmsc_oen_o <= 1'b1;
        end else begin
            if (tckc_rise_i) begin
                case (pkt_pos_i)
                    PKT_NTDI: begin
                        // New packet, probe drives TMSC again
                        tck_o      <= 1'b0;
                        tmsc_oen_o <= 1'b1;
                    end
                    PKT_TMS: begin
                        // nTDI from the previous fall, inverted on the wire
                        tdi_o <= ~tmsc_bit_i;
                    end
                    PKT_TDO: begin
                        // TMS captured, clock the TAP and turn TMSC around
                        tms_o      <= tmsc_bit_i;
                        tck_o      <= 1'b1;
                        tmsc_oen_o <= 1'b0;
                    end
                    default: begin
                        tmsc_oen_o <= 1'b1;
                    end
                endcase
            end
            // End of the TCK pulse
            if (tckc_fall_i && (pkt_pos_i == PKT_TDO)) begin
                tck_o <= 1'b0;
            end
        end
    end

    // TDO passes straight through during the third bit
    assign tmsc_o = tdo_slot ? tdo_i : 1'b0;

endmodule

// File: cjtag_bridge.sv
// cJTAG to JTAG bridge, IEEE 1149.7 OScan1 subset
// Turns two-pin TCKC/TMSC into four-pin TCK/TMS/TDI/TDO,
// sampled from a fast system clock
`timescale 1ns/1ps

module cjtag_bridge (
    input  logic clk_i,
    input  logic ntrst_i,
    input  logic tckc_i,
    input  logic tmsc_i,
    input  logic tdo_i,
    output logic tmsc_o,
    output logic tmsc_oen_o,
    output logic tck_o,
    output logic tms_o,
    output logic tdi_o,
    output logic online_o,
    output logic nsp_o
);
    import bridge_pkg::*;

    // Per-pin sampler signals, indexed by PIN_TCKC and PIN_TMSC
    logic [NUM_PINS-1:0] pin_in;
    logic [NUM_PINS-1:0] pin_level;
    logic [NUM_PINS-1:0] pin_rise;
    logic [NUM_PINS-1:0] pin_fall;
    logic [NUM_PINS-1:0] pin_toggle;

    logic          esc_select;
    logic          esc_reset;
    bridge_state_t state;
    pkt_pos_t      pkt_pos;
    logic          tmsc_bit;

    assign pin_in[PIN_TCKC] = tckc_i;
    assign pin_in[PIN_TMSC] = tmsc_i;

    // ==============================
    // Pin samplers
    // ==============================
    for (genvar i = 0; i < NUM_PINS; i++) begin : g_pin
        pin_sampler u_sampler (
            .clk_i    (clk_i),
            .ntrst_i  (ntrst_i),
            .pin_i    (pin_in[i]),
            .level_o  (pin_level[i]),
            .rise_o   (pin_rise[i]),
            .fall_o   (pin_fall[i]),
            .toggle_o (pin_toggle[i])
        );
    end

    // ==============================
    // Escape, FSM and TAP side
    // ==============================
    // Deselection keeps the current state in this subset, so it has no sink
    escape_detector u_escape (
        .clk_i          (clk_i),
        .ntrst_i        (ntrst_i),
        .tckc_rise_i    (pin_rise[PIN_TCKC]),
        .tckc_fall_i    (pin_fall[PIN_TCKC]),
        .tckc_level_i   (pin_level[PIN_TCKC]),
        .tmsc_toggle_i  (pin_toggle[PIN_TMSC]),
        .esc_select_o   (esc_select),
        .esc_reset_o    (esc_reset),
        .esc_deselect_o ()
    );

    oscan1_controller u_ctrl (
        .clk_i        (clk_i),
        .ntrst_i      (ntrst_i),
        .tckc_fall_i  (pin_fall[PIN_TCKC]),
        .tmsc_level_i (pin_level[PIN_TMSC]),
        .esc_select_i (esc_select),
        .esc_reset_i  (esc_reset),
        .state_o      (state),
        .pkt_pos_o    (pkt_pos),
        .tmsc_bit_o   (tmsc_bit),
        .online_o     (online_o),
        .nsp_o        (nsp_o)
    );

    tap_driver u_tap (
        .clk_i       (clk_i),
        .ntrst_i     (ntrst_i),
        .tckc_rise_i (pin_rise[PIN_TCKC]),
        .tckc_fall_i (pin_fall[PIN_TCKC]),
        .state_i     (state),
        .pkt_pos_i   (pkt_pos),
        .tmsc_bit_i  (tmsc_bit),
        .tdo_i       (tdo_i),
        .tck_o       (tck_o),
        .tms_o       (tms_o),
        .tdi_o       (tdi_o),
        .tmsc_o      (tmsc_o),
        .tmsc_oen_o  (tmsc_oen_o)
    );

endmodule

// File: cjtag_bridge_checker.sv
// Bridge status checker
// Concurrent rules tying the status pins to the JTAG side activity
`timescale 1ns/1ps

module cjtag_bridge_checker (
    input logic clk_i,
    input logic ntrst_i,
    input logic online_i,
    input logic nsp_i,
    input logic tck_i,
    input logic tmsc_oen_i
);
    // Count of failed rules
    int assert_fail_cnt = 0;

    // Status pins are complementary
    a_nsp_inverse: assert property (@(posedge clk_i) disable iff (!ntrst_i)
        nsp_i == !online_i)
        else begin
            assert_fail_cnt++;
            $error("nsp_o is not the inverse of online_o");
        end

    // Bridge only drives TMSC while online
    a_oen_online: assert property (@(posedge clk_i) disable iff (!ntrst_i)
        !tmsc_oen_i |-> online_i)
        else begin
            assert_fail_cnt++;
            $error("tmsc_oen_o low while offline");
        end

    // No TAP clock while offline
    a_tck_online: assert property (@(posedge clk_i) disable iff (!ntrst_i)
        tck_i |-> online_i)
        else begin
            assert_fail_cnt++;
            $error("tck_o high while offline");
        end

endmodule

bind cjtag_bridge cjtag_bridge_checker u_checker (
    .clk_i      (clk_i),
    .ntrst_i    (ntrst_i),
    .online_i   (online_o),
    .nsp_i      (nsp_o),
    .tck_i      (tck_o),
    .tmsc_oen_i (tmsc_oen_o)
);

// File: tb_cjtag_bridge.sv
// Testbench for the cJTAG to JTAG bridge
// Walks a table of escapes, activation codes and OScan1 packets,
// checks the JTAG side and the status pins against the protocol rules
`timescale 1ns/1ps

module tb_cjtag_bridge;
    import cjtag_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CLKS = 10;
    // Clocks per TCKC phase and per escape toggle
    localparam int PHASE      = 5;
    // Worst row is two 9-toggle escapes, 4 OAC bits and 4 packets
    localparam int ROW_CLKS   = 400;

    logic clk_i = 1'b0;
    logic ntrst_i;
    logic tckc_i;
    logic tmsc_i;
    logic tdo_i;
    logic tmsc_o;
    logic tmsc_oen_o;
    logic tck_o;
    logic tms_o;
    logic tdi_o;
    logic online_o;
    logic nsp_o;

    // Stimulus table, one entry per row in each queue
    int         esc_q[$];
    logic [3:0] oac_q[$];
    int         oac_len_q[$];
    int         pkt_q[$];
    logic       exp_q[$];
    logic       table_ready = 1'b0;

    integer seed;
    int     pass_cnt;
    int     fail_cnt;
    int     row_err;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    cjtag_bridge dut_i (
        .clk_i      (clk_i),
        .ntrst_i    (ntrst_i),
        .tckc_i     (tckc_i),
        .tmsc_i     (tmsc_i),
        .tdo_i      (tdo_i),
        .tmsc_o     (tmsc_o),
        .tmsc_oen_o (tmsc_oen_o),
        .tck_o      (tck_o),
        .tms_o      (tms_o),
        .tdi_o      (tdi_o),
        .online_o   (online_o),
        .nsp_o      (nsp_o)
    );

    // ==============================
    // Table and rules
    // ==============================
    task automatic add_row(input int esc, input logic [3:0] oac, input int oac_len,
                           input int pkts, input logic exp_online);
        esc_q.push_back(esc);
        oac_q.push_back(oac);
        oac_len_q.push_back(oac_len);
        pkt_q.push_back(pkts);
        exp_q.push_back(exp_online);
    endtask

    task automatic load_table();
        add_row(6, 4'b1011, 4, 3, 1'b1);
        add_row(7, 4'b1011, 4, 2, 1'b1);
        // Deselection window
        add_row(4, 4'b1011, 4, 1, 1'b0);
        add_row(5, 4'b1011, 4, 0, 1'b0);
        // Wrong activation code
        add_row(6, 4'b1101, 4, 1, 1'b0);
        add_row(7, 4'b0011, 4, 0, 1'b0);
        // Too few toggles for any escape
        add_row(3, 4'b1011, 4, 1, 1'b0);
        add_row(2, 4'b1011, 4, 0, 1'b0);
        // Activation cut short, next reset escape hits it mid code
        add_row(6, 4'b1011, 2, 0, 1'b0);
        add_row(7, 4'b1011, 4, 4, 1'b1);
    endtask

    // Online only after a selection escape and the full correct code
    function automatic logic online_rule(input int esc, input logic [3:0] oac,
                                         input int oac_len);
        return (esc >= ESC_SELECT_MIN) && (esc <= ESC_SELECT_MAX) &&
               (oac_len == OAC_BITS) && (oac == OAC_CODE);
    endfunction

    // ==============================
    // Pin level tasks
    // ==============================
    task automatic wait_clks(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_cnt++;
            row_err++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_idle(input string where);
        check_bit(online_o, 1'b0, {where, ": online_o"});
        check_bit(nsp_o, 1'b1, {where, ": nsp_o"});
        check_bit(tck_o, 1'b0, {where, ": tck_o"});
        check_bit(tms_o, 1'b1, {where, ": tms_o"});
        check_bit(tdi_o, 1'b0, {where, ": tdi_o"});
        check_bit(tmsc_oen_o, 1'b1, {where, ": tmsc_oen_o"});
        check_bit(tmsc_o, 1'b0, {where, ": tmsc_o"});
    endtask

    // TMSC set up in the low phase, then TCKC high; returns before the fall
    task automatic rise_with(input logic b);
        tmsc_i = b;
        wait_clks(PHASE);
        tckc_i = 1'b1;
        wait_clks(PHASE);
    endtask

    // TMSC held through the low phase so the fall samples a settled level
    task automatic fall_and_hold();
        tckc_i = 1'b0;
        wait_clks(PHASE);
    endtask

    task automatic send_escape(input int toggles);
        rise_with(tmsc_i);
        repeat (toggles) begin
            tmsc_i = ~tmsc_i;
            wait_clks(PHASE);
        end
        fall_and_hold();
    endtask

    // LSB first
    task automatic send_oac(input logic [3:0] value, input int len);
        for (int i = 0; i < len; i++) begin
            rise_with(value[i]);
            fall_and_hold();
        end
    endtask

    task automatic send_packet(input logic ntdi, input logic tms, input logic tdo,
                               input logic online);
        // nTDI bit, TMSC back to input after the last packet
        rise_with(ntdi);
        check_bit(tmsc_oen_o, 1'b1, "tmsc_oen_o in nTDI bit");
        check_bit(tck_o, 1'b0, "tck_o in nTDI bit");
        fall_and_hold();
        rise_with(tms);
        check_bit(tdi_o, online ? ~ntdi : 1'b0, "tdi_o in TMS bit");
        fall_and_hold();
        // TDO bit, the target answers on TMSC
        tdo_i = tdo;
        rise_with(tms);
        check_bit(tck_o, online, "tck_o in TDO bit");
        check_bit(tms_o, online ? tms : 1'b1, "tms_o in TDO bit");
        check_bit(tdi_o, online ? ~ntdi : 1'b0, "tdi_o in TDO bit");
        check_bit(tmsc_oen_o, ~online, "tmsc_oen_o in TDO bit");
        check_bit(tmsc_o, online ? tdo : 1'b0, "tmsc_o in TDO bit");
        fall_and_hold();
        check_bit(tck_o, 1'b0, "tck_o after TDO bit");
    endtask

    task automatic leave_online(input int toggles);
        send_escape(toggles);
        wait_clks(2);
        check_idle("after reset escape");
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin : main_seq
        logic [31:0] rnd;
        int          asrt_fail;
        seed     = 32'h9b70_6076;
        ntrst_i  = 1'b0;
        tckc_i   = 1'b0;
        tmsc_i   = 1'b0;
        tdo_i    = 1'b0;
        pass_cnt = 0;
        fail_cnt = 0;
        row_err  = 0;
        load_table();
        table_ready = 1'b1;
        wait_clks(RESET_CLKS);
        ntrst_i = 1'b1;
        wait_clks(2);
        check_idle("after reset");
        $display("Reset: idle outputs, %0d errors", row_err);

        for (int r = 0; r < esc_q.size(); r++) begin
            row_err = 0;
            // Every row starts offline, from OScan1, activation or offline
            leave_online(ESC_RESET_MIN + r % 2);
            if (online_rule(esc_q[r], oac_q[r], oac_len_q[r]) !== exp_q[r]) begin
                fail_cnt++;
                row_err++;
                $display("Table row %0d does not follow the escape and OAC rules", r);
            end
            send_escape(esc_q[r]);
            send_oac(oac_q[r], oac_len_q[r]);
            check_bit(online_o, exp_q[r], "online_o after OAC");
            check_bit(nsp_o, ~exp_q[r], "nsp_o after OAC");
            for (int p = 0; p < pkt_q[r]; p++) begin
                rnd = $random(seed);
                send_packet(rnd[0], rnd[1], rnd[2], exp_q[r]);
            end
            $display("Row %0d: escape %0d, OAC %b (%0d bits), %0d packets, online %b: %0d errors",
                     r, esc_q[r], oac_q[r], oac_len_q[r], pkt_q[r], exp_q[r], row_err);
        end

        row_err = 0;
        leave_online(ESC_RESET_MIN + 1);
        $display("Closing reset escape: %0d errors", row_err);

        asrt_fail = dut_i.u_checker.assert_fail_cnt;
        $display("Checks passed: %0d, failed: %0d, assertion failures: %0d",
                 pass_cnt, fail_cnt, asrt_fail);
        if (fail_cnt == 0 && asrt_fail == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Reset, every row and the closing escape, doubled for margin
    initial begin : watchdog
        longint limit_ns;
        wait (table_ready === 1'b1);
        limit_ns = 2 * (RESET_CLKS + (esc_q.size() + 1) * ROW_CLKS) * CLK_PERIOD;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: list.f
cjtag_pkg.sv
bridge_pkg.sv
pin_sampler.sv
escape_detector.sv
oscan1_controller.sv
tap_driver.sv
cjtag_bridge.sv
cjtag_bridge_checker.sv
tb_cjtag_bridge.sv

// File: Bender.yml
package:
  name: cjtag_bridge

sources:
  - cjtag_pkg.sv
  - bridge_pkg.sv
  - pin_sampler.sv
  - escape_detector.sv
  - oscan1_controller.sv
  - tap_driver.sv
  - cjtag_bridge.sv
  - target: simulation
    files:
      - cjtag_bridge_checker.sv
      - tb_cjtag_bridge.sv
